//--- sources.f
+incdir+.
n64_video_pkg.sv
n64_apb_pkg.sv
n64_vinfo_if.sv
n64_vinfo_ext.sv
n64_vdemux.sv
n64_cfg_regs.sv
n64_video_top.sv
tb_n64_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the N64 video front end testbench with Verilator and runs it
# the result is taken from the pass line in sim.log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log \
  && verilator --binary --timing --assert -j 0 --top-module tb_n64_video \
       -f sources.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

//--- tb_n64_model.svh
// reference model of the video info, the demuxed pixel and the APB registers
// one call per falling nclk edge, taking the DUT inputs as driven for that edge
`ifndef TB_N64_MODEL_SVH
`define TB_N64_MODEL_SVH

// ==============================
// model state
// ==============================

n64_video_pkg::sync_t    m_sync_cur;   // last sync byte
logic [1:0]              m_data_cnt;   // byte phase
logic                    m_frame_id;   // 1 = odd frame seen last
logic                    m_480i;
logic [1:0]              m_line_cnt;
n64_video_pkg::vmode_e   m_vmode;
logic                    m_nblank;     // 0 = blurry position
logic [`N64_COLOR_W-1:0] m_red;
logic [`N64_COLOR_W-1:0] m_green;
n64_video_pkg::pixel_t   m_rgb;        // expected rgb output
logic                    m_valid;      // expected pixel_valid
n64_apb_pkg::ctrl_t      m_ctrl;
logic [15:0]             m_pixcnt;
int                      m_held;       // pixels that kept the old output

task automatic model_reset();
  m_sync_cur = '1;                     // all sync inactive
  m_data_cnt = 2'd0;
  m_frame_id = 1'b0;
  m_480i     = 1'b1;
  m_line_cnt = 2'd0;
  m_vmode    = n64_video_pkg::VMODE_NTSC;
  m_nblank   = 1'b0;
  m_red      = '0;
  m_green    = '0;
  m_rgb      = '0;
  m_valid    = 1'b0;
  m_ctrl     = '0;
  m_pixcnt   = '0;
  m_held     = 0;
endtask

// 15 bit look keeps the upper 5 bits of a color
function automatic logic [`N64_COLOR_W-1:0] drop_lsbs(input logic [`N64_COLOR_W-1:0] c,
                                                     input logic en);
  return en ? {c[`N64_COLOR_W-1:2], 2'b00} : c;
endfunction

task automatic model_step();
  n64_video_pkg::sync_t  sy;
  n64_video_pkg::sync_t  prev;
  n64_video_pkg::vmode_e was_vmode;
  logic [1:0]            dcnt;
  logic                  was_480i;
  logic                  was_nblank;
  logic                  odd;
  sy         = n64_video_pkg::sync_t'(d[`N64_SYNC_W-1:0]);
  prev       = m_sync_cur;
  dcnt       = m_data_cnt;
  was_480i   = m_480i;
  was_nblank = m_nblank;
  was_vmode  = m_vmode;

  // counter sees the strobe from the edge before, a write clears it first
  if (psel && penable && pwrite && paddr == n64_apb_pkg::REG_PIXCNT)
    m_pixcnt = '0;
  else if (m_valid)
    m_pixcnt = m_pixcnt + 16'd1;

  // color bytes by phase
  m_valid = (dcnt == 2'd3);
  if (dcnt == 2'd1)
    m_red = d;
  if (dcnt == 2'd2)
    m_green = d;
  if (dcnt == 2'd3) begin
    if (m_ctrl.deblur_en && !was_480i && !was_nblank) begin
      m_held++;                          // blurry pixel, output unchanged
    end else begin
      m_rgb.red   = drop_lsbs(m_red, m_ctrl.mask_15bit);
      m_rgb.green = drop_lsbs(m_green, m_ctrl.mask_15bit);
      m_rgb.blue  = drop_lsbs(d, m_ctrl.mask_15bit);
    end
  end

  // new ctrl only counts from the next edge on
  if (psel && penable && pwrite && paddr == n64_apb_pkg::REG_CTRL)
    m_ctrl = n64_apb_pkg::ctrl_t'(pwdata[1:0]);

  if (ndsync) begin
    m_data_cnt = dcnt + 2'd1;
  end else begin
    m_data_cnt = 2'd1;
    m_sync_cur = sy;
    if (prev.nvsync && !sy.nvsync) begin
      odd        = prev.nhsync && !sy.nhsync;  // hsync falls with vsync
      m_480i     = odd ? ~m_frame_id : m_frame_id;
      m_frame_id = odd;
    end
    if (!prev.nvsync && sy.nvsync) begin
      m_vmode    = m_line_cnt[1] ? n64_video_pkg::VMODE_NTSC : n64_video_pkg::VMODE_PAL;
      m_line_cnt = 2'd0;
    end else if (!prev.nhsync && sy.nhsync) begin
      m_line_cnt = m_line_cnt + 2'd1;
    end
    if (was_480i)
      m_nblank = 1'b0;
    else if (!prev.ncsync && sy.ncsync)
      m_nblank = (was_vmode == n64_video_pkg::VMODE_NTSC);
    else
      m_nblank = ~was_nblank;
  end
endtask

`endif

//--- tb_n64_video.sv
// testbench for the N64 video front end, random frames checked against a model
// inputs change 5 ns after the rising edge, the DUT samples on the falling edge
`timescale 1ns/1ps
`default_nettype none

`include "n64rgb_params.svh"

module tb_n64_video;

  localparam logic [3:0] SYNC_ACTIVE  = 4'hF;  // no sync
  localparam logic [3:0] SYNC_HSYNC   = 4'hC;  // nhsync and ncsync low
  localparam logic [3:0] SYNC_VS_EVEN = 4'h6;  // vsync alone
  localparam logic [3:0] SYNC_VS_ODD  = 4'h4;  // vsync with hsync
  localparam int         FRAME_CYCLES = 2000;  // timeout per frame

  logic                    nclk = 1'b0;
  logic                    rst_n;
  logic                    ndsync;
  logic [`N64_COLOR_W-1:0] d;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`N64_APB_AW-1:0]  paddr;
  logic [`N64_APB_DW-1:0]  pwdata;
  logic [`N64_APB_DW-1:0]  prdata;
  logic                    pready;
  logic                    pslverr;
  n64_video_pkg::pixel_t   rgb;
  n64_video_pkg::sync_t    sync_out;
  logic                    pixel_valid;

  integer seed = 32'h31d8;
  string  test_name = "reset";
  logic   cfg_480i = 1'b0;    // alternate odd and even frames
  logic   cfg_pal = 1'b0;     // PAL line count parity
  int     frames_sent = 0;

  `include "tb_n64_model.svh"

  always #50 nclk = ~nclk;

  n64_video_top DUT (
    .nclk        (nclk),
    .rst_n       (rst_n),
    .ndsync      (ndsync),
    .d           (d),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .rgb         (rgb),
    .sync_out    (sync_out),
    .pixel_valid (pixel_valid)
  );

  // ==============================
  // compare tasks
  // ==============================

  task automatic stop_on_error();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pixel(input string what, input n64_video_pkg::pixel_t exp,
                             input n64_video_pkg::pixel_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_sync(input string what, input n64_video_pkg::sync_t exp,
                            input n64_video_pkg::sync_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_status(input string what, input n64_apb_pkg::status_t exp,
                              input n64_apb_pkg::status_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_ctrl(input string what, input n64_apb_pkg::ctrl_t exp,
                            input n64_apb_pkg::ctrl_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string what, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  // ==============================
  // stream driver
  // ==============================

  // outputs hold the result of the falling edge before this rising edge
  task automatic send_byte(input logic ds, input logic [`N64_COLOR_W-1:0] b);
    @(posedge nclk);
    check_flag("pixel_valid", m_valid, pixel_valid);
    check_pixel("rgb", m_rgb, rgb);
    check_sync("sync_out", m_sync_cur, sync_out);
    #5;
    ndsync = ds;
    d      = b;
    #5;
    model_step();                        // APB inputs are settled too by now
  endtask

  task automatic send_pixel(input logic [3:0] sy);
    logic [31:0] rnd;
    send_byte(1'b0, {3'b000, sy});
    repeat (3) begin
      rnd = $random(seed);
      send_byte(1'b1, rnd[`N64_COLOR_W-1:0]);  // red, green, blue
    end
  endtask

  initial begin : stream_gen
    logic odd;
    int   lines;
    int   act;
    rst_n  = 1'b0;
    ndsync = 1'b1;
    d      = '0;
    odd    = 1'b0;
    model_reset();
    repeat (10) @(posedge nclk);
    #5;
    rst_n = 1'b1;
    #5;
    model_step();                        // idle byte on the first edge out of reset
    forever begin
      odd   = cfg_480i ? ~odd : 1'b0;
      // line count mod 4 is 2 or 3 for NTSC, 0 or 1 for PAL
      lines = 4 * (1 + {$random(seed)} % 3) + (cfg_pal ? 0 : 2) + {$random(seed)} % 2;
      act   = 3 + {$random(seed)} % 4;
      repeat (2) send_pixel(odd ? SYNC_VS_ODD : SYNC_VS_EVEN);
      repeat (lines) begin
        send_pixel(SYNC_HSYNC);
        repeat (act) send_pixel(SYNC_ACTIVE);
      end
      frames_sent++;
    end
  end

  // ==============================
  // APB and wait tasks
  // ==============================

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge nclk);
    #5;
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge nclk);
    #5;
    penable = 1'b1;                      // access edge is the next falling edge
    #20;
    check_flag("pready", 1'b1, pready);
    check_flag("pslverr", 1'b0, pslverr);
    @(posedge nclk);
    #5;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // also returns the model registers as they stand during the access phase
  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err,
                          output n64_apb_pkg::ctrl_t ctrl_now, output logic [15:0] cnt_now);
    @(posedge nclk);
    #5;
    psel     = 1'b1;
    pwrite   = 1'b0;
    paddr    = addr;
    @(posedge nclk);
    #5;
    penable  = 1'b1;
    ctrl_now = m_ctrl;
    cnt_now  = m_pixcnt;
    #20;
    data     = prdata;
    err      = pslverr;
    check_flag("pready", 1'b1, pready);
    @(posedge nclk);
    #5;
    psel     = 1'b0;
    penable  = 1'b0;
  endtask

  task automatic expect_status(input logic i480, input n64_video_pkg::vmode_e vm);
    n64_apb_pkg::status_t exp_st;
    n64_apb_pkg::ctrl_t   c;
    logic [31:0]          rdata;
    logic [15:0]          n;
    logic                 err;
    exp_st.n64_480i = i480;
    exp_st.vmode    = vm;
    apb_read(n64_apb_pkg::REG_STATUS, rdata, err, c, n);
    check_flag("pslverr", 1'b0, err);
    check_status("REG_STATUS", exp_st, n64_apb_pkg::status_t'(rdata[1:0]));
  endtask

  task automatic expect_ctrl(input logic [1:0] val);
    n64_apb_pkg::ctrl_t c;
    logic [31:0]        rdata;
    logic [15:0]        n;
    logic               err;
    apb_read(n64_apb_pkg::REG_CTRL, rdata, err, c, n);
    check_flag("pslverr", 1'b0, err);
    check_ctrl("REG_CTRL", n64_apb_pkg::ctrl_t'(val), n64_apb_pkg::ctrl_t'(rdata[1:0]));
  endtask

  task automatic wait_frames(input int n);
    int target;
    int cycles;
    target = frames_sent + n;
    cycles = 0;
    while (frames_sent < target) begin
      @(posedge nclk);
      cycles++;
      if (cycles > FRAME_CYCLES * n) begin
        $display("timeout: the stream generator did not finish its frames");
        stop_on_error();
      end
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge nclk);
      cycles++;
      if (cycles > 50) begin
        $display("timeout: reset was never released");
        stop_on_error();
      end
    end
  endtask

  // ==============================
  // main test
  // ==============================

  initial begin : main_test
    n64_apb_pkg::ctrl_t ctrl_now;
    logic [31:0]        rdata;
    logic [15:0]        cnt_now;
    logic               err;
    int                 held_mark;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    wait_reset_release();

    test_name = "demux_240p_ntsc";       // rgb and sync_out checked every cycle
    wait_frames(3);
    expect_status(1'b0, n64_video_pkg::VMODE_NTSC);

    test_name = "deblur_240p";
    apb_write(n64_apb_pkg::REG_CTRL, 32'h1);
    expect_ctrl(2'b01);
    held_mark = m_held;
    wait_frames(2);
    check_flag("blurry pixels held", 1'b1, m_held > held_mark);

    test_name = "vmode_pal";
    cfg_pal = 1'b1;
    wait_frames(3);
    expect_status(1'b0, n64_video_pkg::VMODE_PAL);

    test_name = "mode_480i";             // deblur still on
    cfg_480i = 1'b1;
    cfg_pal  = 1'b0;
    wait_frames(3);
    expect_status(1'b1, n64_video_pkg::VMODE_NTSC);
    held_mark = m_held;
    wait_frames(2);
    check_flag("pixel held in 480i", 1'b0, m_held != held_mark);

    test_name = "mask_15bit";
    cfg_480i = 1'b0;
    apb_write(n64_apb_pkg::REG_CTRL, 32'h2);
    expect_ctrl(2'b10);
    wait_frames(3);

    test_name = "pixel_count";
    apb_write(n64_apb_pkg::REG_PIXCNT, 32'h0);
    wait_frames(1);
    apb_read(n64_apb_pkg::REG_PIXCNT, rdata, err, ctrl_now, cnt_now);
    check_flag("pslverr", 1'b0, err);
    check_flag("pixels counted", 1'b1, cnt_now != 16'd0);
    check_count("REG_PIXCNT", cnt_now, rdata[15:0]);

    test_name = "bad_address";
    apb_read(4'hC, rdata, err, ctrl_now, cnt_now);
    check_flag("pslverr", 1'b1, err);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- n64_video_top.sv
// N64 video front end, all logic on the falling edge of nclk
// APB runs on nclk as well, no clock crossing
`timescale 1ns/1ps
`default_nettype none

`include "n64rgb_params.svh"

module n64_video_top (
  input  logic                    nclk,
  input  logic                    rst_n,
  input  logic                    ndsync,
  input  logic [`N64_COLOR_W-1:0] d,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`N64_APB_AW-1:0]  paddr,
  input  logic [`N64_APB_DW-1:0]  pwdata,
  output logic [`N64_APB_DW-1:0]  prdata,
  output logic                    pready,
  output logic                    pslverr,
  output n64_video_pkg::pixel_t   rgb,
  output n64_video_pkg::sync_t    sync_out,
  output logic                    pixel_valid
);

  // control from the register block
  logic deblur_en;
  logic mask_15bit;

  n64_vinfo_if vinfo_bus ();

  // ==============================
  // video path
  // ==============================

  n64_vinfo_ext u_vinfo_ext (
    .nclk   (nclk),
    .rst_n  (rst_n),
    .ndsync (ndsync),
    .d      (d),
    .vinfo  (vinfo_bus.src)
  );

  n64_vdemux u_vdemux (
    .nclk        (nclk),
    .rst_n       (rst_n),
    .d           (d),
    .vinfo       (vinfo_bus.demux_mp),
    .deblur_en   (deblur_en),
    .mask_15bit  (mask_15bit),
    .rgb         (rgb),
    .sync_out    (sync_out),
    .pixel_valid (pixel_valid)
  );

  // register block, counts pixels from the demux
  n64_cfg_regs u_cfg_regs (
    .nclk        (nclk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .vinfo       (vinfo_bus.regs_mp),
    .pixel_valid (pixel_valid),
    .deblur_en   (deblur_en),
    .mask_15bit  (mask_15bit)
  );

endmodule

`default_nettype wire

//--- n64_cfg_regs.sv
// APB3 slave on nclk, zero wait states; unknown addresses answer with pslverr
// REG_STATUS is read only, writes to it are ignored
`timescale 1ns/1ps
`default_nettype none

`include "n64rgb_params.svh"

module n64_cfg_regs (
  input  logic                   nclk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`N64_APB_AW-1:0] paddr,
  input  logic [`N64_APB_DW-1:0] pwdata,
  output logic [`N64_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  n64_vinfo_if.regs_mp           vinfo,
  input  logic                   pixel_valid,
  output logic                   deblur_en,
  output logic                   mask_15bit
);

  n64_apb_pkg::ctrl_t        ctrl_q;
  n64_apb_pkg::status_t      status;
  logic [`N64_PIXCNT_W-1:0]  pixcnt_q;   // pixel_valid pulses since last clear
  logic                      access;     // APB access phase
  logic                      addr_ok;

  assign access = psel & penable;
  assign pready = 1'b1;                 // no wait states

  // live view of the extractor
  assign status.n64_480i = vinfo.n64_480i;
  assign status.vmode    = vinfo.vmode;

  // ==============================
  // address decode and read mux
  // ==============================

  always_comb begin
    addr_ok = 1'b1;
    prdata  = '0;
    case (n64_apb_pkg::reg_addr_e'(paddr))
      n64_apb_pkg::REG_CTRL:   prdata = `N64_APB_DW'(ctrl_q);
      n64_apb_pkg::REG_STATUS: prdata = `N64_APB_DW'(status);
      n64_apb_pkg::REG_PIXCNT: prdata = `N64_APB_DW'(pixcnt_q);
      default:                 addr_ok = 1'b0;
    endcase
    if (!access)
      prdata = '0;                      // only driven in the access phase
  end

  assign pslverr = access & ~addr_ok;

  // ==============================
  // register writes
  // ==============================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q   <= '0;
      pixcnt_q <= '0;
    end else begin
      if (access && pwrite && paddr == n64_apb_pkg::REG_CTRL)
        ctrl_q <= n64_apb_pkg::ctrl_t'(pwdata[$bits(n64_apb_pkg::ctrl_t)-1:0]);
      if (access && pwrite && paddr == n64_apb_pkg::REG_PIXCNT)
        pixcnt_q <= '0;                 // any write clears, wins over a pulse
      else if (pixel_valid)
        pixcnt_q <= pixcnt_q + 1'b1;    // wraps at 16 bit
    end
  end

  assign deblur_en  = ctrl_q.deblur_en;
  assign mask_15bit = ctrl_q.mask_15bit;

  // access phase only within a selected transfer
  a_penable_psel : assert property (
    @(negedge nclk) disable iff (!rst_n) penable |-> psel);

endmodule

`default_nettype wire

//--- n64_vdemux.sv
// demuxes red, green and blue bytes into one registered pixel per 4 byte group
// assumes a continuous stream; deblur only acts in 240p
`timescale 1ns/1ps
`default_nettype none

`include "n64rgb_params.svh"

module n64_vdemux (
  input  logic                    nclk,
  input  logic                    rst_n,
  input  logic [`N64_COLOR_W-1:0] d,
  n64_vinfo_if.demux_mp           vinfo,
  input  logic                    deblur_en,
  input  logic                    mask_15bit,
  output n64_video_pkg::pixel_t   rgb,
  output n64_video_pkg::sync_t    sync_out,
  output logic                    pixel_valid
);

  // clears the two lsbs of a color
  localparam logic [`N64_COLOR_W-1:0] LSB_MASK = ~(`N64_COLOR_W'(3));

  logic [`N64_COLOR_W-1:0] red_q;     // red byte of the current pixel
  logic [`N64_COLOR_W-1:0] green_q;   // green byte of the current pixel
  n64_video_pkg::pixel_t   pix_new;   // assembled at the blue phase
  n64_video_pkg::pixel_t   pix_out;   // after the 15 bit option
  logic                    blue_phase;
  logic                    hold_pix;

  // ==============================
  // color capture
  // ==============================

  always_ff @(negedge nclk) begin
    if (vinfo.data_cnt == 2'd1)
      red_q <= d;
    if (vinfo.data_cnt == 2'd2)
      green_q <= d;
  end

  assign blue_phase = (vinfo.data_cnt == 2'd3);  // blue on the bus now

  always_comb begin
    pix_new.red   = red_q;
    pix_new.green = green_q;
    pix_new.blue  = d;
  end

  // 15 bit look, drop the 2 lsbs per channel
  always_comb begin
    pix_out = pix_new;
    if (mask_15bit) begin
      pix_out.red   = pix_new.red   & LSB_MASK;
      pix_out.green = pix_new.green & LSB_MASK;
      pix_out.blue  = pix_new.blue  & LSB_MASK;
    end
  end

  // blurry pixel in 240p, repeat the last one
  assign hold_pix = deblur_en & ~vinfo.n64_480i & ~vinfo.nblank_rgb;

  // ==============================
  // pixel output
  // ==============================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      rgb         <= '0;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= blue_phase;       // strobe also for held pixels
      if (blue_phase && !hold_pix)
        rgb <= pix_out;
    end
  end

  // sync byte is registered by the extractor on the sync edge
  assign sync_out = vinfo.sync_cur;

  // one pixel per 4 bytes, never back to back
  a_valid_single : assert property (
    @(negedge nclk) disable iff (!rst_n) pixel_valid |=> !pixel_valid);

endmodule

`default_nettype wire

//--- n64_vinfo_ext.sv
// extracts byte phase, 240p/480i, PAL/NTSC and blurry pixel position from the N64 bus
// sync edges are taken between the stored sync byte and the one on the bus at ndsync low
`timescale 1ns/1ps
`default_nettype none

`include "n64rgb_params.svh"

module n64_vinfo_ext (
  input  logic                    nclk,
  input  logic                    rst_n,
  input  logic                    ndsync,
  input  logic [`N64_COLOR_W-1:0] d,
  n64_vinfo_if.src                vinfo
);

  n64_video_pkg::sync_t sync_in;   // sync byte currently on d
  logic                 posedge_nvsync;
  logic                 negedge_nvsync;
  logic                 posedge_nhsync;
  logic                 negedge_nhsync;
  logic                 posedge_ncsync;
  logic                 frame_id;  // 1 = odd frame, 0 = even frame
  logic [1:0]           line_cnt;  // PAL: 0x at vsync, NTSC: 1x

  assign sync_in = n64_video_pkg::sync_t'(d[`N64_SYNC_W-1:0]);

  // edges between previous (stored) and current sync word
  assign posedge_nvsync = ~vinfo.sync_cur.nvsync &  sync_in.nvsync;
  assign negedge_nvsync =  vinfo.sync_cur.nvsync & ~sync_in.nvsync;
  assign posedge_nhsync = ~vinfo.sync_cur.nhsync &  sync_in.nhsync;
  assign negedge_nhsync =  vinfo.sync_cur.nhsync & ~sync_in.nhsync;
  assign posedge_ncsync = ~vinfo.sync_cur.ncsync &  sync_in.ncsync;

  // ==============================
  // data phase counter
  // ==============================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      vinfo.data_cnt <= 2'd0;
      vinfo.sync_cur <= n64_video_pkg::SYNC_IDLE;
    end else if (!ndsync) begin
      vinfo.data_cnt <= 2'd1;          // red follows
      vinfo.sync_cur <= sync_in;       // keep for next edge compare
    end else begin
      vinfo.data_cnt <= vinfo.data_cnt + 2'd1;  // wraps to 0 on the sync byte
    end
  end

  // ==============================
  // 240p / 480i estimation
  // ==============================

  // 240p sends only one frame parity, 480i alternates
  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_id       <= 1'b0;
      vinfo.n64_480i <= 1'b1;
    end else if (!ndsync && negedge_nvsync) begin
      if (negedge_nhsync) begin        // hsync falls too, odd frame
        vinfo.n64_480i <= ~frame_id;
        frame_id       <= 1'b1;
      end else begin                   // even frame
        vinfo.n64_480i <= frame_id;
        frame_id       <= 1'b0;
      end
    end
  end

  // ==============================
  // vmode and blurry pixel
  // ==============================

  always_ff @(negedge nclk or negedge rst_n) begin
    if (!rst_n) begin
      line_cnt         <= 2'd0;
      vinfo.vmode      <= n64_video_pkg::VMODE_NTSC;
      vinfo.nblank_rgb <= 1'b0;
    end else if (!ndsync) begin
      if (posedge_nvsync) begin        // new frame, line parity gives the mode
        line_cnt    <= 2'd0;
        vinfo.vmode <= n64_video_pkg::vmode_e'(~line_cnt[1]);
      end else if (posedge_nhsync) begin
        line_cnt <= line_cnt + 2'd1;
      end
      if (!vinfo.n64_480i) begin       // 240p
        if (posedge_ncsync)
          vinfo.nblank_rgb <= ~vinfo.vmode;  // line start sets the blur phase
        else
          vinfo.nblank_rgb <= ~vinfo.nblank_rgb;  // alternates per pixel
      end else begin
        vinfo.nblank_rgb <= 1'b0;
      end
    end
  end

  // red phase always directly after the sync byte
  a_dcnt_after_sync : assert property (
    @(negedge nclk) disable iff (!rst_n) !ndsync |=> (vinfo.data_cnt == 2'd1));

  // once cleared in 480i the blur position stays cleared
  a_no_blur_480i : assert property (
    @(negedge nclk) disable iff (!rst_n)
    (vinfo.n64_480i && !vinfo.nblank_rgb) |=> !vinfo.nblank_rgb);

endmodule

`default_nettype wire

//--- n64_vinfo_if.sv
// video info from the extractor, valid on every falling nclk edge
// no handshake, consumers sample the values directly
`timescale 1ns/1ps
`default_nettype none

interface n64_vinfo_if;

  logic [1:0]            data_cnt;    // byte phase, 1 = red on the bus
  logic                  n64_480i;    // 1 = 480i/576i, 0 = 240p/288p
  n64_video_pkg::vmode_e vmode;       // PAL / NTSC from line count
  logic                  nblank_rgb;  // 0 = blurry pixel position
  n64_video_pkg::sync_t  sync_cur;    // last sync byte seen

  // extractor drives everything
  modport src (
    output data_cnt, n64_480i, vmode, nblank_rgb, sync_cur
  );

  // demux needs the phase, blur position and the stored sync byte
  modport demux_mp (
    input data_cnt, n64_480i, nblank_rgb, sync_cur
  );

  // status register view
  modport regs_mp (
    input n64_480i, vmode
  );

endinterface

`default_nettype wire

//--- n64_apb_pkg.sv
// register map and field layout of the APB control block
// status vmode is encoded as n64_video_pkg::vmode_e
`default_nettype none

`include "n64rgb_params.svh"

package n64_apb_pkg;

  // byte addresses of the registers
  typedef enum logic [`N64_APB_AW-1:0] {
    REG_CTRL   = 4'h0,  // r/w control
    REG_STATUS = 4'h4,  // ro live video info
    REG_PIXCNT = 4'h8   // pixel counter, write clears
  } reg_addr_e;

  // control fields, deblur_en at bit 0
  typedef struct packed {
    logic mask_15bit;   // clear 2 lsbs of each color
    logic deblur_en;    // hold blurry pixels in 240p
  } ctrl_t;

  // status fields, n64_480i at bit 0
  typedef struct packed {
    n64_video_pkg::vmode_e vmode;
    logic                  n64_480i;
  } status_t;

endpackage

`default_nettype wire

//--- n64_video_pkg.sv
// video side types of the N64 front end
// sync_t follows the bit order of the console sync byte, nvsync at bit 3
`default_nettype none

`include "n64rgb_params.svh"

package n64_video_pkg;

  // ==============================
  // video mode
  // ==============================

  typedef enum logic {
    VMODE_NTSC = 1'b0,  // line_cnt[1] set at vsync
    VMODE_PAL  = 1'b1   // line_cnt[1] clear at vsync
  } vmode_e;

  // sync byte, all signals active low
  typedef struct packed {
    logic nvsync;   // bit 3
    logic nclamp;   // bit 2
    logic nhsync;   // bit 1
    logic ncsync;   // bit 0
  } sync_t;

  // no sync active, also the reset value
  localparam sync_t SYNC_IDLE = '1;

  // one demuxed pixel
  typedef struct packed {
    logic [`N64_COLOR_W-1:0] red;
    logic [`N64_COLOR_W-1:0] green;
    logic [`N64_COLOR_W-1:0] blue;
  } pixel_t;

endpackage

`default_nettype wire

//--- n64rgb_params.svh
// widths and constants shared by the N64 video front end
// the color width covers the 7 bit console bus; the sync word sits in its low 4 bits
`ifndef N64RGB_PARAMS_SVH
`define N64RGB_PARAMS_SVH

// ==============================
// video bus
// ==============================

`define N64_COLOR_W 7   // one color byte as driven on d
`define N64_SYNC_W  4   // nvsync, nclamp, nhsync, ncsync

// data phase counter, 4 bytes per pixel
`define N64_DCNT_W  2

// ==============================
// APB register port
// ==============================

`define N64_APB_AW   4    // byte address, 3 registers in use
`define N64_APB_DW   32   // register data width
`define N64_PIXCNT_W 16   // width of the pixel counter register

`endif
